// ==== include/dma_defs.svh ====
// dma engine macros: tlp payload size, sample fifo geometry and thresholds, widths, control bits
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// tlp and sample fifo
//////////////////////////////////////////////////////////////////////
`define DMA_MAX_PAYLOAD_DW      32      // dw per full tlp, 128 bytes
`define DMA_FIFO_AW             9       // 512 words of 64 bits
`define DMA_PROG_EMPTY_THRESH   32      // prog_empty while count <= this
`define DMA_PROG_FULL_THRESH    500     // prog_full while count >= this

// bus widths
`define DMA_SIZE_W              21      // transfer size in bytes, max 1 MB
`define DMA_DATA_W              64      // pcie user data path

//////////////////////////////////////////////////////////////////////
// control word bits, kept adjacent with enable on top
//////////////////////////////////////////////////////////////////////
`define DMA_DMAE_BIT            23      // dma enable, transfer starts on rising edge
`define DMA_DMAIE_BIT           22      // interrupt enable
`define DMA_RST_BIT             21      // sample fifo clear

`endif

// ==== rtl/dma_ctrl_pkg.sv ====
// register side types: control word, status word, interrupt fsm states
`include "dma_defs.svh"

package dma_ctrl_pkg;

    // host control word, fields land on the macro bit positions
    typedef struct packed {
        logic [30-`DMA_DMAE_BIT:0]  rsvd_hi;    // unused upper bits
        logic                       dmae;       // bit DMA_DMAE_BIT
        logic                       dmaie;      // bit DMA_DMAIE_BIT
        logic                       fifo_rst;   // bit DMA_RST_BIT
        logic [`DMA_RST_BIT-1:0]    rsvd_lo;    // unused lower bits
    } ctrl_word_t;

    // status word read back by the host
    typedef struct packed {
        logic [2:0] rsvd;           // always zero
        logic       prog_empty;     // sample fifo below threshold
        logic       done;           // sticky until host acknowledge
        logic [2:0] buf_cnt;        // finished transfers, wraps
    } dma_status_t;

    // interrupt hand-off to the pcie core
    typedef enum logic {
        IRQ_IDLE,                   // waiting for a delayed end pulse
        IRQ_WAIT_RDY                // cfg_interrupt held until core ready
    } irq_state_e;

endpackage

// ==== rtl/dma_tlp_pkg.sv ====
// tlp side types: write request to the tx engine, sequencer fsm states

package dma_tlp_pkg;

    // one write request handed to the tx engine
    typedef struct packed {
        logic [7:0]  payload_dw;    // length in double words
        logic [31:0] host_addr;     // byte address in host memory
    } tlp_req_t;

    // request sequencer states
    typedef enum logic [2:0] {
        SEQ_IDLE,                   // wait for start flag and host address
        SEQ_FIRST,                  // issue first tlp of the transfer
        SEQ_NEXT,                   // issue following tlps or finish
        SEQ_WAIT_COMPL,             // tx engine busy with current tlp
        SEQ_REQ_END                 // one cycle end marker
    } tlp_state_e;

endpackage

// ==== rtl/dma_sample_fifo.sv ====
// single clock fwft sample fifo with prog_empty/prog_full flags and sync clear
`include "dma_defs.svh"

module dma_sample_fifo (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    clear_i,        // sync flush from control word
    input  logic                    wr_en_i,
    input  logic [`DMA_DATA_W-1:0]  wr_data_i,
    input  logic                    rd_en_i,        // pops the head word
    output logic [`DMA_DATA_W-1:0]  rd_data_o,      // head word, zero latency
    output logic                    prog_empty_o,
    output logic                    prog_full_o
);

    localparam logic [`DMA_FIFO_AW:0] DEPTH    = 1 << `DMA_FIFO_AW;
    localparam logic [`DMA_FIFO_AW:0] EMPTY_TH = `DMA_PROG_EMPTY_THRESH;
    localparam logic [`DMA_FIFO_AW:0] FULL_TH  = `DMA_PROG_FULL_THRESH;

    logic [`DMA_DATA_W-1:0]  mem [0:DEPTH-1];
    logic [`DMA_FIFO_AW-1:0] wr_ptr;
    logic [`DMA_FIFO_AW-1:0] rd_ptr;
    logic [`DMA_FIFO_AW:0]   count;            // one extra bit to tell full from empty
    logic                    wr_ok;
    logic                    rd_ok;

    assign wr_ok = wr_en_i && (count != DEPTH);     // drop writes when full
    assign rd_ok = rd_en_i && (count != '0);        // ignore reads when empty

    //////////////////////////////////////////////////////////////////////
    // pointers and word count
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok)
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
            if (rd_ok)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither, level unchanged
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (wr_ok)
            mem[wr_ptr] <= wr_data_i;
    end

    assign rd_data_o    = mem[rd_ptr];          // fwft, head always visible
    assign prog_empty_o = (count <= EMPTY_TH);  // not enough for a full tlp
    assign prog_full_o  = (count >= FULL_TH);   // source must hold off

endmodule

// ==== rtl/dma_tlp_sequencer.sv ====
// tlp sequencer: start edge detect, size split, request fsm, address stepping, buffer counter
`include "dma_defs.svh"

module dma_tlp_sequencer (
    input  logic                        pcie_user_clk,
    input  logic                        pcie_user_rst_n,
    input  dma_ctrl_pkg::ctrl_word_t    ctrl_i,
    input  logic [`DMA_SIZE_W-1:0]      dma_size_i,         // bytes
    input  logic [31:0]                 host_addr_i,        // zero blocks the start
    input  logic [5:0]                  tx_buf_av_i,        // core tx buffers free
    input  logic                        fifo_prog_empty_i,
    input  logic                        tlp_compl_done_i,   // tx engine finished a tlp
    output logic                        tlp_req_o,          // level until completion
    output dma_tlp_pkg::tlp_req_t       tlp_o,
    output logic                        seq_end_o,
    output logic [2:0]                  buf_cnt_o
);
    import dma_tlp_pkg::*;

    localparam int          SIZE_DW_W     = `DMA_SIZE_W - 2;
    localparam int          PL_SHIFT      = $clog2(`DMA_MAX_PAYLOAD_DW);
    localparam int          FULL_W        = SIZE_DW_W - PL_SHIFT;
    localparam logic [7:0]  FULL_PAYLOAD  = `DMA_MAX_PAYLOAD_DW;
    localparam logic [31:0] PAYLOAD_BYTES = `DMA_MAX_PAYLOAD_DW * 4;

    logic [SIZE_DW_W-1:0] size_dw;      // size in dw, byte offset dropped
    logic [FULL_W-1:0]    full_cnt;     // number of full tlps
    logic [7:0]           rem_dw;       // dw left for the last short tlp
    logic                 dma_en;
    logic [2:0]           dmae_r;       // enable delay line
    logic                 req_flag;     // start seen, not yet taken
    logic [FULL_W-1:0]    tlps2go;      // full tlps still to issue
    logic                 rem_sent;     // remainder tlp already issued
    tlp_state_e           state;
    logic                 can_issue;
    logic                 more_full;
    logic                 more_rem;
    logic                 issue_first;
    logic                 issue_full;
    logic                 issue_rem;

    //////////////////////////////////////////////////////////////////////
    // size split and issue conditions
    //////////////////////////////////////////////////////////////////////
    assign size_dw  = dma_size_i[`DMA_SIZE_W-1:2];
    assign full_cnt = size_dw[SIZE_DW_W-1:PL_SHIFT];        // size / payload
    assign rem_dw   = 8'(size_dw[PL_SHIFT-1:0]);            // size mod payload
    assign dma_en   = ctrl_i.dmae;

    // back-pressure from the core and the sample fifo
    assign can_issue   = (tx_buf_av_i > 6'd1) && !fifo_prog_empty_i;
    assign more_full   = (tlps2go != '0);
    assign more_rem    = (rem_dw != 8'd0) && !rem_sent;
    assign issue_first = (state == SEQ_FIRST) && dma_en && can_issue;
    assign issue_full  = (state == SEQ_NEXT) && dma_en && can_issue && more_full;
    assign issue_rem   = (state == SEQ_NEXT) && dma_en && can_issue && !more_full && more_rem;

    //////////////////////////////////////////////////////////////////////
    // request fsm
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge pcie_user_clk) begin
        if (!pcie_user_rst_n) begin
            dmae_r    <= '0;
            req_flag  <= 1'b0;
            tlps2go   <= '0;
            rem_sent  <= 1'b0;
            tlp_req_o <= 1'b0;
            buf_cnt_o <= '0;
            state     <= SEQ_IDLE;
        end else begin
            dmae_r <= {dmae_r[1:0], dma_en};
            if (dmae_r[2:1] == 2'b01)               // delayed rising edge of enable
                req_flag <= 1'b1;
            case (state)
                SEQ_IDLE: begin
                    if (req_flag && (host_addr_i != '0))
                        state <= SEQ_FIRST;
                end
                SEQ_FIRST: begin
                    req_flag <= 1'b0;               // start consumed
                    if (!dma_en) begin
                        state <= SEQ_IDLE;          // abort before anything went out
                    end else if (can_issue) begin
                        tlps2go   <= (full_cnt == '0) ? '0 : full_cnt - 1'b1;
                        rem_sent  <= (full_cnt == '0);  // short transfer is the remainder
                        tlp_req_o <= 1'b1;
                        state     <= SEQ_WAIT_COMPL;
                    end
                end
                SEQ_NEXT: begin
                    if (!dma_en) begin
                        state <= SEQ_IDLE;          // aborted, no buffer counted
                    end else if (!more_full && !more_rem) begin
                        buf_cnt_o <= buf_cnt_o + 3'd1;
                        state     <= SEQ_REQ_END;
                    end else if (can_issue) begin
                        if (more_full)
                            tlps2go <= tlps2go - 1'b1;
                        else
                            rem_sent <= 1'b1;       // remainder goes out only once
                        tlp_req_o <= 1'b1;
                        state     <= SEQ_WAIT_COMPL;
                    end
                end
                SEQ_WAIT_COMPL: begin
                    if (tlp_compl_done_i) begin
                        tlp_req_o <= 1'b0;
                        state     <= SEQ_NEXT;
                    end else if (!dma_en) begin
                        tlp_req_o <= 1'b0;          // drop request mid tlp
                        state     <= SEQ_IDLE;
                    end
                end
                SEQ_REQ_END: state <= SEQ_IDLE;
                default:     state <= SEQ_IDLE;
            endcase
        end
    end

    // request payload, stepped by one full tlp per issue
    always_ff @(posedge pcie_user_clk) begin
        if (issue_first) begin
            tlp_o.host_addr  <= host_addr_i;
            tlp_o.payload_dw <= (full_cnt == '0) ? rem_dw : FULL_PAYLOAD;
        end else if (issue_full || issue_rem) begin
            tlp_o.host_addr  <= tlp_o.host_addr + PAYLOAD_BYTES;
            tlp_o.payload_dw <= issue_full ? FULL_PAYLOAD : rem_dw;
        end
    end

    assign seq_end_o = (state == SEQ_REQ_END);      // one cycle pulse

endmodule

// ==== rtl/dma_irq_ctrl.sv ====
// interrupt controller: delayed end pulse, cfg_interrupt hand-off, sticky done flag

module dma_irq_ctrl (
    input  logic pcie_user_clk,
    input  logic pcie_user_rst_n,
    input  logic irq_en_i,              // dmaie bit of the control word
    input  logic seq_end_i,             // transfer finished pulse
    input  logic cfg_interrupt_rdy_i,   // core took the interrupt
    input  logic dma_compl_acq_i,       // host acknowledge of done
    output logic cfg_interrupt_o,
    output logic done_o
);
    import dma_ctrl_pkg::*;

    logic [2:0] end_r;                  // end pulse delay line
    irq_state_e state;

    always_ff @(posedge pcie_user_clk) begin
        if (!pcie_user_rst_n) begin
            end_r           <= '0;
            cfg_interrupt_o <= 1'b0;
            done_o          <= 1'b0;
            state           <= IRQ_IDLE;
        end else begin
            end_r <= {end_r[1:0], seq_end_i};
            case (state)
                IRQ_IDLE: begin
                    if (irq_en_i && end_r[2]) begin
                        cfg_interrupt_o <= 1'b1;
                        done_o          <= 1'b1;    // new completion wins over ack
                        state           <= IRQ_WAIT_RDY;
                    end else if (dma_compl_acq_i) begin
                        done_o <= 1'b0;             // host saw it
                    end
                end
                IRQ_WAIT_RDY: begin
                    if (cfg_interrupt_rdy_i) begin
                        cfg_interrupt_o <= 1'b0;
                        state           <= IRQ_IDLE;
                    end
                end
                default: state <= IRQ_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/pci_dma_engine.sv ====
// dma engine top: sample fifo, tlp sequencer, interrupt controller, pcie byte swap, status
`include "dma_defs.svh"

module pci_dma_engine (
    input  logic                        pcie_user_clk,
    input  logic                        pcie_user_rst_n,
    // host registers
    input  dma_ctrl_pkg::ctrl_word_t    control_i,
    input  logic [`DMA_SIZE_W-1:0]      dma_size_i,
    input  logic [31:0]                 dma_host_addr_i,
    input  logic                        dma_compl_acq_i,
    output dma_ctrl_pkg::dma_status_t   dma_status_o,
    // pcie core
    input  logic [5:0]                  tx_buf_av_i,
    input  logic                        cfg_interrupt_rdy_i,
    output logic                        cfg_interrupt_o,
    // tx engine handshake
    input  logic                        fifo_rd_en_i,
    input  logic                        tlp_compl_done_i,
    output logic                        tlp_req_o,
    output dma_tlp_pkg::tlp_req_t       tlp_o,
    output logic [`DMA_DATA_W-1:0]      dma_data_o,
    // sample source
    input  logic [`DMA_DATA_W-1:0]      sample_i,
    input  logic                        sample_en_i,
    output logic                        data_ready_o
);

    logic [`DMA_DATA_W-1:0] fifo_head;
    logic                   prog_empty;
    logic                   prog_full;
    logic                   seq_end;
    logic                   done;
    logic [2:0]             buf_cnt;

    //////////////////////////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////////////////////////
    dma_sample_fifo u_sample_fifo (
        .clk_i        (pcie_user_clk),
        .rst_n_i      (pcie_user_rst_n),
        .clear_i      (control_i.fifo_rst),
        .wr_en_i      (sample_en_i),
        .wr_data_i    (sample_i),
        .rd_en_i      (fifo_rd_en_i),
        .rd_data_o    (fifo_head),
        .prog_empty_o (prog_empty),
        .prog_full_o  (prog_full)
    );

    dma_tlp_sequencer u_tlp_seq (
        .pcie_user_clk     (pcie_user_clk),
        .pcie_user_rst_n   (pcie_user_rst_n),
        .ctrl_i            (control_i),
        .dma_size_i        (dma_size_i),
        .host_addr_i       (dma_host_addr_i),
        .tx_buf_av_i       (tx_buf_av_i),
        .fifo_prog_empty_i (prog_empty),
        .tlp_compl_done_i  (tlp_compl_done_i),
        .tlp_req_o         (tlp_req_o),
        .tlp_o             (tlp_o),
        .seq_end_o         (seq_end),
        .buf_cnt_o         (buf_cnt)
    );

    dma_irq_ctrl u_irq_ctrl (
        .pcie_user_clk       (pcie_user_clk),
        .pcie_user_rst_n     (pcie_user_rst_n),
        .irq_en_i            (control_i.dmaie),
        .seq_end_i           (seq_end),
        .cfg_interrupt_rdy_i (cfg_interrupt_rdy_i),
        .dma_compl_acq_i     (dma_compl_acq_i),
        .cfg_interrupt_o     (cfg_interrupt_o),
        .done_o              (done)
    );

    // pcie byte order: reverse bytes inside each 32-bit half, halves stay put
    for (genvar b = 0; b < `DMA_DATA_W / 8; b++) begin : g_swap
        assign dma_data_o[8*b +: 8] = fifo_head[8*((b / 4) * 4 + 3 - (b % 4)) +: 8];
    end

    assign dma_status_o = '{rsvd: 3'b000, prog_empty: prog_empty, done: done, buf_cnt: buf_cnt};
    assign data_ready_o = !prog_full;   // source may keep writing

endmodule

// ==== verification/tb_pci_dma_engine.sv ====
// dma engine testbench with clock, reset, transfer table, tx engine model, data and status checks
`include "dma_defs.svh"

module tb_pci_dma_engine;
    timeunit 1ns;
    timeprecision 1ps;
    import dma_ctrl_pkg::*;
    import dma_tlp_pkg::*;

    localparam int WAIT_LIMIT = 2000;               // cycles per wait loop
    localparam int SIG_REQ    = 0;                  // selectors for the wait loop
    localparam int SIG_IRQ    = 1;
    localparam int SIG_DONE   = 2;
    localparam int SIG_BUFCNT = 3;
    localparam int N_ROWS     = 8;

    // one transfer of the table
    typedef struct packed {
        logic [`DMA_SIZE_W-1:0] size;               // bytes in multiples of 8
        logic [31:0]            addr;               // zero means no start
        logic                   irq_en;
        logic                   abort;              // drop enable during first tlp
    } xfer_t;

    xfer_t rows [N_ROWS] = '{
        '{21'd64,   32'h1000_0000, 1'b1, 1'b0},     // remainder only
        '{21'd128,  32'h1000_1000, 1'b0, 1'b0},     // exactly one full tlp
        '{21'd200,  32'h2000_0040, 1'b1, 1'b0},     // full plus remainder
        '{21'd384,  32'h3000_0000, 1'b0, 1'b0},     // three full, no remainder
        '{21'd512,  32'h4000_0000, 1'b1, 1'b1},
        '{21'd1000, 32'h5000_0100, 1'b1, 1'b0},     // 7 full + 26 dw
        '{21'd256,  32'h0000_0000, 1'b1, 1'b0},
        '{21'd136,  32'h6000_0000, 1'b1, 1'b0}      // 2 dw tail
    };
    string row_name [N_ROWS] = '{"short_64b", "one_full_128b", "full_rem_200b",
        "three_full_384b", "abort_mid_tlp", "after_abort_1000b", "zero_addr",
        "after_zero_136b"};

    logic                   pcie_user_clk = 1'b0;
    logic                   pcie_user_rst_n;
    ctrl_word_t             control_i;
    logic [`DMA_SIZE_W-1:0] dma_size_i;
    logic [31:0]            dma_host_addr_i;
    logic                   dma_compl_acq_i;
    dma_status_t            dma_status_o;
    logic [5:0]             tx_buf_av_i;
    logic                   cfg_interrupt_rdy_i;
    logic                   cfg_interrupt_o;
    logic                   fifo_rd_en_i;
    logic                   tlp_compl_done_i;
    logic                   tlp_req_o;
    tlp_req_t               tlp_o;
    logic [`DMA_DATA_W-1:0] dma_data_o;
    logic [`DMA_DATA_W-1:0] sample_i;
    logic                   sample_en_i;
    logic                   data_ready_o;

    logic [31:0]            rng_state = 32'he33dfeec;
    logic [63:0]            sample_q [$];       // words expected at the fifo head in order
    logic [2:0]             exp_buf_cnt = 3'd0;
    string                  cur_test = "reset";
    int                     errors = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;

    pci_dma_engine u_dut (
        .pcie_user_clk       (pcie_user_clk),
        .pcie_user_rst_n     (pcie_user_rst_n),
        .control_i           (control_i),
        .dma_size_i          (dma_size_i),
        .dma_host_addr_i     (dma_host_addr_i),
        .dma_compl_acq_i     (dma_compl_acq_i),
        .dma_status_o        (dma_status_o),
        .tx_buf_av_i         (tx_buf_av_i),
        .cfg_interrupt_rdy_i (cfg_interrupt_rdy_i),
        .cfg_interrupt_o     (cfg_interrupt_o),
        .fifo_rd_en_i        (fifo_rd_en_i),
        .tlp_compl_done_i    (tlp_compl_done_i),
        .tlp_req_o           (tlp_req_o),
        .tlp_o               (tlp_o),
        .dma_data_o          (dma_data_o),
        .sample_i            (sample_i),
        .sample_en_i         (sample_en_i),
        .data_ready_o        (data_ready_o)
    );

    always #50 pcie_user_clk = ~pcie_user_clk;      // 100 ns period

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // bytes reversed within each 32-bit half for pcie order
    function automatic logic [63:0] pcie_order(input logic [63:0] s);
        return {s[39:32], s[47:40], s[55:48], s[63:56],
                s[7:0],   s[15:8],  s[23:16], s[31:24]};
    endfunction

    function automatic logic [7:0] probe(input int sig);
        case (sig)
            SIG_REQ:  return {7'd0, tlp_req_o};
            SIG_IRQ:  return {7'd0, cfg_interrupt_o};
            SIG_DONE: return {7'd0, dma_status_o.done};
            default:  return {5'd0, dma_status_o.buf_cnt};
        endcase
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     cur_test, what, expected, actual);
        end
    endtask

    // outputs sampled just after the edge show the settled pre-edge values
    task automatic wait_for(input int sig, input logic [7:0] value, input string what);
        int cycles;
        cycles = 0;
        do begin
            @(posedge pcie_user_clk);
            cycles++;
        end while (probe(sig) !== value && cycles < WAIT_LIMIT);
        if (probe(sig) !== value) begin
            errors++;
            $display("%s: timed out after %0d cycles waiting for %s", cur_test, cycles, what);
        end
    endtask

    task automatic clear_fifo();
        @(posedge pcie_user_clk);
        control_i.fifo_rst <= 1'b1;
        @(posedge pcie_user_clk);
        control_i.fifo_rst <= 1'b0;                 // clear takes effect on this edge
        sample_q.delete();
    endtask

    task automatic fill_fifo(input int n);
        logic [63:0] word;
        for (int i = 0; i < n; i++) begin
            @(posedge pcie_user_clk);
            rng_state   = xorshift32(rng_state);
            word[63:32] = rng_state;
            rng_state   = xorshift32(rng_state);
            word[31:0]  = rng_state;
            sample_i    <= word;
            sample_en_i <= 1'b1;
            sample_q.push_back(word);
        end
        @(posedge pcie_user_clk);
        sample_en_i <= 1'b0;                        // last word lands on this edge
    endtask

    // tx engine model pops n words and compares each head word
    task automatic read_words(input int n);
        logic [63:0] word;
        fifo_rd_en_i <= 1'b1;
        for (int k = 0; k < n; k++) begin
            @(posedge pcie_user_clk);               // word popped on this edge
            if (sample_q.size() == 0) begin
                errors++;
                $display("%s: the DUT asked for more words than were written", cur_test);
            end else begin
                word = sample_q.pop_front();
                check_value("dma_data_o", pcie_order(word), dma_data_o);
            end
            if (k == n - 1)
                fifo_rd_en_i <= 1'b0;
        end
    endtask

    task automatic report_test(input int errs_before);
        tests_run++;
        if (errors != errs_before)
            tests_failed++;
        $display("test %-20s %s", cur_test, (errors == errs_before) ? "ok" : "FAILED");
    endtask

    //////////////////////////////////////////////////////////////////////
    // one table row with fill, start, tlp service and end of transfer checks
    //////////////////////////////////////////////////////////////////////
    task automatic run_row(input int idx);
        xfer_t       x;
        int          errs_before;
        int          size_dw;
        int          n_full;
        int          n_rem;
        int          n_tlp;
        logic [7:0]  exp_dw;
        logic        seen_req;
        x           = rows[idx];
        cur_test    = row_name[idx];
        errs_before = errors;
        size_dw     = int'(x.size) / 4;
        n_full      = size_dw / `DMA_MAX_PAYLOAD_DW;
        n_rem       = size_dw % `DMA_MAX_PAYLOAD_DW;
        n_tlp       = n_full + ((n_rem != 0) ? 1 : 0);
        @(posedge pcie_user_clk);
        dma_size_i      <= x.size;
        dma_host_addr_i <= x.addr;
        control_i.dmaie <= x.irq_en;
        clear_fifo();
        fill_fifo(int'(x.size) / 8 + 40);           // padding keeps prog_empty low
        @(posedge pcie_user_clk);
        control_i.dmae <= 1'b1;
        if (x.addr == '0) begin
            seen_req = 1'b0;
            repeat (60) begin
                @(posedge pcie_user_clk);
                seen_req |= tlp_req_o;
            end
            check_value("tlp_req_o seen", 0, seen_req);
            check_value("buf_cnt", exp_buf_cnt, dma_status_o.buf_cnt);
        end else begin
            tx_buf_av_i <= 6'd1;                    // one free buffer is not enough to issue
            repeat (20) begin
                @(posedge pcie_user_clk);
                check_value("tlp_req_o while tx_buf_av low", 0, tlp_req_o);
            end
            tx_buf_av_i <= 6'd8;
            for (int t = 0; t < n_tlp; t++) begin
                wait_for(SIG_REQ, 8'd1, "tlp_req_o high");
                exp_dw = (t < n_full) ? 8'(`DMA_MAX_PAYLOAD_DW) : 8'(n_rem);
                check_value("payload_dw", exp_dw, tlp_o.payload_dw);
                check_value("host_addr", x.addr + 32'(t * `DMA_MAX_PAYLOAD_DW * 4),
                            tlp_o.host_addr);
                if (x.abort) begin
                    control_i.dmae <= 1'b0;         // abort while the tlp is pending
                    wait_for(SIG_REQ, 8'd0, "tlp_req_o low after abort");
                    repeat (10) @(posedge pcie_user_clk);
                    check_value("buf_cnt after abort", exp_buf_cnt, dma_status_o.buf_cnt);
                    break;
                end
                read_words((int'(exp_dw) + 1) / 2);
                tlp_compl_done_i <= 1'b1;
                @(posedge pcie_user_clk);
                tlp_compl_done_i <= 1'b0;
                wait_for(SIG_REQ, 8'd0, "tlp_req_o low after completion");
            end
            if (!x.abort) begin
                exp_buf_cnt++;
                wait_for(SIG_BUFCNT, {5'd0, exp_buf_cnt}, "buffer counter increment");
                if (x.irq_en) begin
                    wait_for(SIG_IRQ, 8'd1, "cfg_interrupt_o high");
                    repeat (4) begin                // held until the core is ready
                        @(posedge pcie_user_clk);
                        check_value("cfg_interrupt_o held", 1, cfg_interrupt_o);
                    end
                    cfg_interrupt_rdy_i <= 1'b1;
                    @(posedge pcie_user_clk);
                    cfg_interrupt_rdy_i <= 1'b0;
                    wait_for(SIG_IRQ, 8'd0, "cfg_interrupt_o low after rdy");
                    check_value("done set", 1, dma_status_o.done);
                    dma_compl_acq_i <= 1'b1;
                    @(posedge pcie_user_clk);
                    dma_compl_acq_i <= 1'b0;
                    wait_for(SIG_DONE, 8'd0, "done clear after acknowledge");
                end else begin
                    repeat (12) begin
                        @(posedge pcie_user_clk);
                        check_value("cfg_interrupt_o quiet", 0, cfg_interrupt_o);
                        check_value("done quiet", 0, dma_status_o.done);
                    end
                end
            end
        end
        @(posedge pcie_user_clk);
        control_i.dmae  <= 1'b0;
        control_i.dmaie <= 1'b0;
        report_test(errs_before);
    endtask

    // thresholds with the engine idle
    task automatic check_flow_control();
        int errs_before;
        cur_test    = "flow_control";
        errs_before = errors;
        clear_fifo();
        @(posedge pcie_user_clk);
        check_value("prog_empty at 0", 1, dma_status_o.prog_empty);
        fill_fifo(32);
        @(posedge pcie_user_clk);
        check_value("prog_empty at 32", 1, dma_status_o.prog_empty);
        fill_fifo(1);
        @(posedge pcie_user_clk);
        check_value("prog_empty at 33", 0, dma_status_o.prog_empty);
        fill_fifo(466);
        @(posedge pcie_user_clk);
        check_value("data_ready at 499", 1, data_ready_o);
        fill_fifo(1);
        @(posedge pcie_user_clk);
        check_value("data_ready at 500", 0, data_ready_o);
        clear_fifo();
        @(posedge pcie_user_clk);
        check_value("data_ready after clear", 1, data_ready_o);
        check_value("prog_empty after clear", 1, dma_status_o.prog_empty);
        report_test(errs_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        pcie_user_rst_n     = 1'b0;
        control_i           = '0;
        dma_size_i          = '0;
        dma_host_addr_i     = '0;
        dma_compl_acq_i     = 1'b0;
        tx_buf_av_i         = 6'd8;                 // room in the core tx buffers
        cfg_interrupt_rdy_i = 1'b0;
        fifo_rd_en_i        = 1'b0;
        tlp_compl_done_i    = 1'b0;
        sample_i            = '0;
        sample_en_i         = 1'b0;
        repeat (16) @(posedge pcie_user_clk);
        pcie_user_rst_n <= 1'b1;
        @(posedge pcie_user_clk);
        check_value("tlp_req_o", 0, tlp_req_o);
        check_value("cfg_interrupt_o", 0, cfg_interrupt_o);
        check_value("status", 8'h10, dma_status_o);    // only prog_empty set
        report_test(0);
        for (int r = 0; r < N_ROWS; r++)
            run_row(r);
        check_flow_control();
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
rtl/dma_ctrl_pkg.sv
rtl/dma_tlp_pkg.sv
rtl/dma_sample_fifo.sv
rtl/dma_tlp_sequencer.sv
rtl/dma_irq_ctrl.sv
rtl/pci_dma_engine.sv
verification/tb_pci_dma_engine.sv
